// ==== hdl/ice_mbus_pkg.sv ====
`default_nettype none

package ice_mbus_pkg;

	// one word as handed over by the MBus controller
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        pend;
		logic        fail;
		logic        bcast;
		logic [1:0]  ctrl;
	} rx_word_t;

	// byte stream towards the ICE bus interface
	typedef struct packed {
		logic       frame_valid;
		logic       latch;
		logic [7:0] data;
	} frame_out_t;

	// enumerate / invalidate request from the controller
	typedef struct packed {
		logic       write;
		logic       invalid_n;
		logic [3:0] addr;
	} addr_update_t;

	localparam logic [7:0] frame_flag = 8'h62;
	localparam logic [3:0] addr_none = 4'hf;

	typedef enum logic [1:0] {
		sel_payload,
		sel_flag,
		sel_counter,
		sel_status
	} byte_sel_t;

	typedef enum logic [2:0] {
		idle,
		hdr_flag,
		hdr_ctr,
		rx_capture,
		rx_shift,
		rx_check,
		rx_end,
		fail_ack
	} rx_state_t;

endpackage

`default_nettype wire

// ==== hdl/mbus_clk_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbus_clk_divider #(
	parameter int clk_div_width = 22
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [clk_div_width-1:0] clk_div,
	output logic                     mbus_clk
);

	logic [clk_div_width-1:0] count;

	// half period is clk_div+1 cycles of clk
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			mbus_clk <= 1'b0;
		end else if (count == clk_div) begin
			count <= '0;
			mbus_clk <= ~mbus_clk;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mbus_rx_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbus_rx_bridge #(
	parameter int clk_div_width = 22
) (
	input  logic                       clk,
	input  logic                       reset,
	input  ice_mbus_pkg::rx_word_t     rx_word,
	input  logic                       rxreq,
	input  logic                       rxfail,
	input  ice_mbus_pkg::addr_update_t addr_update,
	input  logic [3:0]                 short_addr_override,
	input  logic [clk_div_width-1:0]   clk_div,
	input  logic [7:0]                 global_counter,
	output logic                       mbus_clk,
	output logic                       rxack,
	output logic [3:0]                 assigned_addr,
	output logic                       assigned_addr_valid,
	output ice_mbus_pkg::frame_out_t   frame,
	output logic                       incr_ctr
);
	import ice_mbus_pkg::*;

	byte_sel_t  byte_sel;
	logic       capture;
	logic       shift;
	logic       clear;
	logic       last_byte;
	logic       cur_pend;
	logic       cur_fail;
	logic [7:0] payload_byte;
	logic [7:0] status_byte;
	logic       frame_valid;
	logic       latch;

	mbus_clk_divider #(
		.clk_div_width(clk_div_width)
	) clk_div_inst (
		.clk(clk),
		.reset(reset),
		.clk_div(clk_div),
		.mbus_clk(mbus_clk)
	);

	short_addr_reg short_addr_inst (
		.clk(clk),
		.reset(reset),
		.addr_update(addr_update),
		.short_addr_override(short_addr_override),
		.assigned_addr(assigned_addr),
		.assigned_addr_valid(assigned_addr_valid)
	);

	rx_word_shifter shifter_inst (
		.clk(clk),
		.reset(reset),
		.rx_word(rx_word),
		.capture(capture),
		.shift(shift),
		.clear(clear),
		.payload_byte(payload_byte),
		.last_byte(last_byte)
	);

	rx_status_collector status_inst (
		.clk(clk),
		.reset(reset),
		.rx_word(rx_word),
		.capture(capture),
		.clear(clear),
		.status_byte(status_byte),
		.cur_pend(cur_pend),
		.cur_fail(cur_fail)
	);

	rx_frame_fsm fsm_inst (
		.clk(clk),
		.reset(reset),
		.rxreq(rxreq),
		.rxfail(rxfail),
		.last_byte(last_byte),
		.cur_pend(cur_pend),
		.cur_fail(cur_fail),
		.capture(capture),
		.shift(shift),
		.clear(clear),
		.byte_sel(byte_sel),
		.frame_valid(frame_valid),
		.latch(latch),
		.rxack(rxack),
		.incr_ctr(incr_ctr)
	);

	// output byte mux
	always_comb begin
		frame.frame_valid = frame_valid;
		frame.latch = latch;
		case (byte_sel)
			sel_flag:    frame.data = frame_flag;
			sel_counter: frame.data = global_counter;
			sel_status:  frame.data = status_byte;
			default:     frame.data = payload_byte;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/rx_frame_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_fsm (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    rxreq,
	input  logic                    rxfail,
	input  logic                    last_byte,
	input  logic                    cur_pend,
	input  logic                    cur_fail,
	output logic                    capture,
	output logic                    shift,
	output logic                    clear,
	output ice_mbus_pkg::byte_sel_t byte_sel,
	output logic                    frame_valid,
	output logic                    latch,
	output logic                    rxack,
	output logic                    incr_ctr
);
	import ice_mbus_pkg::*;

	rx_state_t  state;
	rx_state_t  next_state;
	logic [1:0] rxreq_sync;
	logic [1:0] rxfail_sync;
	logic       req_s;
	logic       fail_s;
	logic [1:0] state_cnt;
	logic       ack_next;

	// controller handshake lives on mbus_clk
	assign req_s = rxreq_sync[1];
	assign fail_s = rxfail_sync[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			rxreq_sync <= '0;
			rxfail_sync <= '0;
			state_cnt <= '0;
			rxack <= 1'b0;
		end else begin
			rxreq_sync <= {rxreq_sync[0], rxreq};
			rxfail_sync <= {rxfail_sync[0], rxfail};
			state <= next_state;
			rxack <= ack_next;
			// cycles spent in the current state
			if (next_state != state) begin
				state_cnt <= '0;
			end else begin
				state_cnt <= state_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (req_s) begin
					next_state = hdr_flag;
				end else if (fail_s) begin
					next_state = fail_ack;
				end
			end
			hdr_flag: next_state = hdr_ctr;
			hdr_ctr: begin
				if (state_cnt == 2'd1) begin
					next_state = rx_capture;
				end
			end
			rx_capture: next_state = rx_shift;
			rx_shift: begin
				if (last_byte) begin
					next_state = rx_check;
				end
			end
			rx_check: begin
				// a failed word ends the message even with pend set
				if (!cur_pend || cur_fail) begin
					next_state = rx_end;
				end else if (req_s) begin
					next_state = rx_capture;
				end
			end
			rx_end: next_state = idle;
			fail_ack: begin
				if (state_cnt == 2'd2) begin
					next_state = idle;
				end
			end
			default: next_state = idle;
		endcase
	end

	// ack lines up with the capture cycle, fail ack trails by one
	assign ack_next = (next_state == rx_capture) || (state == fail_ack);

	assign capture = (state == rx_capture);
	assign shift = (state == rx_shift);
	assign clear = (state == idle);
	assign incr_ctr = (state == hdr_ctr) && (state_cnt == 2'd1);

	assign frame_valid = (state != idle) && (state != fail_ack);
	assign latch = (state == hdr_flag) || (state == rx_shift) || (state == rx_end) ||
		((state == hdr_ctr) && (state_cnt == 2'd0));

	always_comb begin
		case (state)
			hdr_flag: byte_sel = sel_flag;
			hdr_ctr:  byte_sel = sel_counter;
			rx_end:   byte_sel = sel_status;
			default:  byte_sel = sel_payload;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/rx_status_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_status_collector (
	input  logic                   clk,
	input  logic                   reset,
	input  ice_mbus_pkg::rx_word_t rx_word,
	input  logic                   capture,
	input  logic                   clear,
	output logic [7:0]             status_byte,
	output logic                   cur_pend,
	output logic                   cur_fail
);

	always_ff @(posedge clk) begin
		if (reset) begin
			status_byte <= 8'h00;
			cur_pend <= 1'b0;
			cur_fail <= 1'b0;
		end else if (clear) begin
			status_byte <= 8'h00;
		end else if (capture) begin
			// sticky over all words of one message
			status_byte <= status_byte |
				{4'b0000, rx_word.fail, rx_word.bcast, rx_word.ctrl};
			cur_pend <= rx_word.pend;
			cur_fail <= rx_word.fail;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rx_word_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_word_shifter (
	input  logic                   clk,
	input  logic                   reset,
	input  ice_mbus_pkg::rx_word_t rx_word,
	input  logic                   capture,
	input  logic                   shift,
	input  logic                   clear,
	output logic [7:0]             payload_byte,
	output logic                   last_byte
);

	logic [63:0] shift_reg;
	logic [2:0]  byte_cnt;
	logic        first_word;

	// bytes left in the current word, minus one
	always_ff @(posedge clk) begin
		if (reset) begin
			byte_cnt <= '0;
			first_word <= 1'b1;
		end else if (clear) begin
			first_word <= 1'b1;
		end else if (capture) begin
			first_word <= 1'b0;
			if (first_word) begin
				byte_cnt <= 3'd7;
			end else begin
				byte_cnt <= 3'd3;
			end
		end else if (shift) begin
			byte_cnt <= byte_cnt - 1'b1;
		end
	end

	// first word carries the address, later words only data
	always_ff @(posedge clk) begin
		if (capture) begin
			if (first_word) begin
				shift_reg <= {rx_word.addr, rx_word.data};
			end else begin
				shift_reg <= {rx_word.data, 32'd0};
			end
		end else if (shift) begin
			shift_reg <= {shift_reg[55:0], 8'h00};
		end
	end

	assign payload_byte = shift_reg[63:56];
	assign last_byte = (byte_cnt == 3'd0);

endmodule

`default_nettype wire

// ==== hdl/short_addr_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module short_addr_reg (
	input  logic                       clk,
	input  logic                       reset,
	input  ice_mbus_pkg::addr_update_t addr_update,
	input  logic [3:0]                 short_addr_override,
	output logic [3:0]                 assigned_addr,
	output logic                       assigned_addr_valid
);
	import ice_mbus_pkg::*;

	logic [3:0] stored_addr;
	logic       stored_valid;

	// enumerate write wins over invalidate
	always_ff @(posedge clk) begin
		if (reset) begin
			stored_addr <= addr_none;
			stored_valid <= 1'b0;
		end else if (addr_update.write) begin
			stored_addr <= addr_update.addr;
			stored_valid <= 1'b1;
		end else if (!addr_update.invalid_n) begin
			stored_addr <= addr_none;
			stored_valid <= 1'b0;
		end
	end

	// user override from the ICE host, f means not set
	always_comb begin
		if (short_addr_override != addr_none) begin
			assigned_addr = short_addr_override;
			assigned_addr_valid = 1'b1;
		end else begin
			assigned_addr = stored_addr;
			assigned_addr_valid = stored_valid;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mbus_rx_bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mbus_rx_bridge_tb \
	-f verilog.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation ended with status $run_status"
	exit 1
fi
exit 0

// ==== sim/mbus_rx_bridge_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbus_rx_bridge_assert (
	input logic clk,
	input logic reset,
	input logic frame_valid,
	input logic latch,
	input logic rxack,
	input logic shift,
	input logic incr_ctr
);

	// bytes only inside a frame
	latch_in_frame: assert property (@(posedge clk) disable iff (reset)
		latch |-> frame_valid)
		else $error("latch high outside a frame");

	no_ack_in_shift: assert property (@(posedge clk) disable iff (reset)
		shift |-> !rxack)
		else $error("rxack high while shifting payload");

	// time tag request is a single pulse
	incr_single_pulse: assert property (@(posedge clk) disable iff (reset)
		incr_ctr |=> !incr_ctr)
		else $error("incr_ctr longer than one cycle");

endmodule

bind rx_frame_fsm mbus_rx_bridge_assert fsm_assert_inst (
	.clk(clk),
	.reset(reset),
	.frame_valid(frame_valid),
	.latch(latch),
	.rxack(rxack),
	.shift(shift),
	.incr_ctr(incr_ctr)
);

`default_nettype wire

// ==== sim/mbus_rx_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbus_rx_bridge_tb;
	import ice_mbus_pkg::*;

	localparam int clk_div_width = 22;
	localparam int max_records = 64;
	localparam int record_bound_ns = 2000;

	logic                     clk;
	logic                     reset;
	rx_word_t                 rx_word;
	logic                     rxreq;
	logic                     rxfail;
	addr_update_t             addr_update;
	logic [3:0]               short_addr_override;
	logic [clk_div_width-1:0] clk_div;
	logic [7:0]               global_counter;
	logic                     mbus_clk;
	logic                     rxack;
	logic [3:0]               assigned_addr;
	logic                     assigned_addr_valid;
	frame_out_t               frame;
	logic                     incr_ctr;

	// kind, flags, addr, data per record
	logic [75:0] patterns [0:max_records-1];
	int          num_records;
	logic        records_ready;
	int          frame_count;
	int          incr_count;
	logic [31:0] lcg_state;
	logic [7:0]  exp_ctr;
	logic [7:0]  exp_status;
	logic [3:0]  model_addr;
	logic        model_valid;
	logic        in_msg;
	logic [7:0]  exp_q [$];
	logic [7:0]  got_q [$];

	mbus_rx_bridge #(
		.clk_div_width(clk_div_width)
	) mbus_rx_bridge_inst (
		.clk(clk),
		.reset(reset),
		.rx_word(rx_word),
		.rxreq(rxreq),
		.rxfail(rxfail),
		.addr_update(addr_update),
		.short_addr_override(short_addr_override),
		.clk_div(clk_div),
		.global_counter(global_counter),
		.mbus_clk(mbus_clk),
		.rxack(rxack),
		.assigned_addr(assigned_addr),
		.assigned_addr_valid(assigned_addr_valid),
		.frame(frame),
		.incr_ctr(incr_ctr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// collect every latched byte
	always @(posedge clk) begin
		if (!reset && frame.latch === 1'b1) begin
			got_q.push_back(frame.data);
		end
	end

	// time tag owner
	always @(posedge clk) begin
		if (incr_ctr === 1'b1) begin
			incr_count++;
			#1;
			global_counter = global_counter + 8'd1;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic next_edge();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_edge();
	endtask

	task automatic random_gap();
		lcg_state = lcg_next(lcg_state);
		wait_cycles(int'(lcg_state[18:16]) + 1);
	endtask

	task automatic check_addr();
		if (short_addr_override != 4'hf) begin
			check_value("assigned_addr", 32'(assigned_addr), 32'(short_addr_override));
			check_value("assigned_addr_valid", 32'(assigned_addr_valid), 32'd1);
		end else begin
			check_value("assigned_addr", 32'(assigned_addr), 32'(model_addr));
			check_value("assigned_addr_valid", 32'(assigned_addr_valid), 32'(model_valid));
		end
	endtask

	// outputs right after reset is released
	task automatic check_reset_outputs();
		check_value("frame.frame_valid", 32'(frame.frame_valid), 32'd0);
		check_value("frame.latch", 32'(frame.latch), 32'd0);
		check_value("rxack", 32'(rxack), 32'd0);
		check_value("incr_ctr", 32'(incr_ctr), 32'd0);
		check_value("mbus_clk", 32'(mbus_clk), 32'd0);
	endtask

	// controller side of the level handshake
	task automatic send_word(input logic [75:0] rec);
		rx_word.addr = rec[63:32];
		rx_word.data = rec[31:0];
		rx_word.pend = rec[68];
		rx_word.fail = rec[67];
		rx_word.bcast = rec[66];
		rx_word.ctrl = rec[65:64];
		rxreq = 1'b1;
		while (rxack !== 1'b1) begin
			next_edge();
		end
		// word is captured at the end of the ack cycle
		next_edge();
		rxreq = 1'b0;
	endtask

	task automatic compare_frame();
		check_value("frame length", 32'(got_q.size()), 32'(exp_q.size()));
		for (int i = 0; i < exp_q.size(); i++) begin
			check_value("frame.data", 32'(got_q[i]), 32'(exp_q[i]));
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic word_record(input logic [75:0] rec);
		if (!in_msg) begin
			random_gap();
			exp_q.delete();
			exp_q.push_back(8'h62);
			exp_q.push_back(exp_ctr);
			for (int i = 3; i >= 0; i--) begin
				exp_q.push_back(rec[32+8*i +: 8]);
			end
			exp_status = 8'h00;
			in_msg = 1'b1;
		end else begin
			random_gap();
		end
		for (int i = 3; i >= 0; i--) begin
			exp_q.push_back(rec[8*i +: 8]);
		end
		exp_status = exp_status | {4'b0000, rec[67:64]};
		send_word(rec);
		if (!rec[68]) begin
			while (frame.frame_valid !== 1'b0) begin
				next_edge();
			end
			exp_q.push_back(exp_status);
			compare_frame();
			in_msg = 1'b0;
			exp_ctr = exp_ctr + 8'd1;
			frame_count++;
		end
	endtask

	task automatic fail_record();
		rxfail = 1'b1;
		while (rxack !== 1'b1) begin
			next_edge();
		end
		// a fail in idle opens no frame
		check_value("frame.frame_valid", 32'(frame.frame_valid), 32'd0);
		rxfail = 1'b0;
		while (rxack !== 1'b0) begin
			next_edge();
		end
		wait_cycles(3);
		check_value("latched bytes after fail", 32'(got_q.size()), 32'd0);
	endtask

	task automatic update_record(input logic [75:0] rec);
		addr_update.write = rec[65];
		addr_update.invalid_n = rec[64];
		addr_update.addr = rec[3:0];
		if (rec[65]) begin
			model_addr = rec[3:0];
			model_valid = 1'b1;
		end else if (!rec[64]) begin
			model_addr = 4'hf;
			model_valid = 1'b0;
		end
		next_edge();
		addr_update.write = 1'b0;
		addr_update.invalid_n = 1'b1;
		check_addr();
	endtask

	// divisor change goes with a reset so the counter restarts
	task automatic divider_record(input logic [75:0] rec);
		logic level;
		int   cnt;
		clk_div = rec[clk_div_width-1:0];
		reset = 1'b1;
		wait_cycles(3);
		reset = 1'b0;
		model_addr = 4'hf;
		model_valid = 1'b0;
		check_reset_outputs();
		check_addr();
		level = mbus_clk;
		while (mbus_clk === level) begin
			next_edge();
		end
		repeat (2) begin
			level = mbus_clk;
			cnt = 0;
			while (mbus_clk === level) begin
				next_edge();
				cnt++;
			end
			check_value("mbus_clk half period", 32'(cnt), 32'(clk_div) + 32'd1);
		end
	endtask

	initial begin
		wait (records_ready === 1'b1);
		#(num_records * record_bound_ns + 1000);
		$display("watchdog expired before all records were done");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		logic [75:0] rec;
		reset = 1'b1;
		rx_word = '0;
		rxreq = 1'b0;
		rxfail = 1'b0;
		addr_update.write = 1'b0;
		addr_update.invalid_n = 1'b1;
		addr_update.addr = 4'h0;
		short_addr_override = 4'hf;
		clk_div = '0;
		global_counter = 8'h3c;
		exp_ctr = 8'h3c;
		exp_status = 8'h00;
		model_addr = 4'hf;
		model_valid = 1'b0;
		in_msg = 1'b0;
		frame_count = 0;
		incr_count = 0;
		num_records = 0;
		records_ready = 1'b0;
		lcg_state = 32'heea5155c;
		$readmemh("sim/rx_patterns.hex", patterns);
		while (num_records < max_records && patterns[num_records][75:72] !== 4'h0) begin
			num_records++;
		end
		if (num_records == 0) begin
			$display("pattern file holds no records");
			$display("TEST FAIL");
			$fatal(1, "no stimulus");
		end
		records_ready = 1'b1;
		wait_cycles(3);
		reset = 1'b0;
		check_reset_outputs();
		check_addr();
		for (int r = 0; r < num_records; r++) begin
			rec = patterns[r];
			case (rec[75:72])
				4'h1: word_record(rec);
				4'h2: fail_record();
				4'h3: update_record(rec);
				4'h4: begin
					short_addr_override = rec[3:0];
					#1;
					check_addr();
				end
				4'h5: divider_record(rec);
				default: begin
					$display("unknown record kind in pattern file");
					$display("TEST FAIL");
					$fatal(1, "bad pattern file");
				end
			endcase
		end
		check_value("incr_ctr pulses", 32'(incr_count), 32'(frame_count));
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/rx_patterns.hex ====
// kind_flags_addr_data: kind 1 word, 2 fail in idle, 3 addr update, 4 override, 5 divisor, 0 end
// word flags 10 pend 08 fail 04 bcast 03 ctrl, update flags 2 write 1 invalid_n
5_00_00000000_00000003
5_00_00000000_00000000
1_00_a5a5f00d_01234567
1_16_00000040_deadbeef
1_01_00000000_cafef00d
2_00_00000000_00000000
1_08_00000011_0badc0de
3_03_00000000_00000005
4_00_00000000_00000009
4_00_00000000_0000000f
3_00_00000000_00000000
1_11_00000022_11111111
1_10_00000000_22222222
1_04_00000000_33333333
5_00_00000000_00000006
0_00_00000000_00000000

// ==== verilog.f ====
hdl/ice_mbus_pkg.sv
hdl/mbus_clk_divider.sv
hdl/short_addr_reg.sv
hdl/rx_word_shifter.sv
hdl/rx_status_collector.sv
hdl/rx_frame_fsm.sv
hdl/mbus_rx_bridge.sv
sim/mbus_rx_bridge_assert.sv
sim/mbus_rx_bridge_tb.sv
